// File: source/afifo_cfg_pkg.sv
package afifo_cfg_pkg;

  // word and storage sizing
  localparam int unsigned DATA_W = 8;
  localparam int unsigned DEPTH  = 16;
  localparam int unsigned ADDR_W = 4;   // log2 of DEPTH

  // pointers carry one extra wrap bit above the address
  localparam int unsigned PTR_W  = ADDR_W + 1;

  // default flag thresholds, in used entries
  // afull once the count reaches this level
  localparam int unsigned AFULL_DEF  = 15;

  // aempty while the count is at or below this level
  localparam int unsigned AEMPTY_DEF = 1;

endpackage

// File: source/afifo_types_pkg.sv
package afifo_types_pkg;

  // one stored word
  typedef logic [afifo_cfg_pkg::DATA_W-1:0] data_t;

  // index into the storage array
  typedef logic [afifo_cfg_pkg::ADDR_W-1:0] addr_t;

  // address plus wrap bit
  // same type holds the binary and the gray form
  typedef logic [afifo_cfg_pkg::PTR_W-1:0]  ptr_t;

endpackage

// File: source/afifo_ram_if.sv
interface afifo_ram_if;

  // write port, wr_clk domain
  logic                   wr_en;
  afifo_types_pkg::addr_t wr_addr;
  afifo_types_pkg::data_t wr_data;

  // read port, rd_clk domain
  logic                   rd_en;
  afifo_types_pkg::addr_t rd_addr;
  afifo_types_pkg::data_t rd_data;

  modport ctrl (
    output wr_en,
    output wr_addr,
    output wr_data,
    output rd_en,
    output rd_addr,
    input  rd_data
  );

  modport mem (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

// File: source/afifo_dpram.sv
module afifo_dpram (
  input  logic        wr_clk,
  input  logic        rd_clk,
  input  logic        rd_rst_n,
  afifo_ram_if.mem    ram
);

  afifo_types_pkg::data_t mem [afifo_cfg_pkg::DEPTH];
  afifo_types_pkg::data_t rd_q;

  // write side, one word per accepted write
  always_ff @(posedge wr_clk) begin
    if (ram.wr_en) begin
      mem[ram.wr_addr] <= ram.wr_data;
    end
  end

  // registered read
  // holds its value when no read is accepted
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_q <= '0;
    end else if (ram.rd_en) begin
      rd_q <= mem[ram.rd_addr];
    end
  end

  assign ram.rd_data = rd_q;

endmodule

// File: source/afifo_ptr_domain.sv
module afifo_ptr_domain (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  inc,
  input  afifo_types_pkg::ptr_t far_gray,
  output afifo_types_pkg::ptr_t ptr_bin,
  output afifo_types_pkg::ptr_t ptr_bin_nxt,
  output afifo_types_pkg::ptr_t ptr_gray,
  output afifo_types_pkg::ptr_t far_bin
);

  localparam int unsigned PW = afifo_cfg_pkg::PTR_W;

  afifo_types_pkg::ptr_t bin_q;
  afifo_types_pkg::ptr_t bin_nxt;
  afifo_types_pkg::ptr_t gray_q;
  afifo_types_pkg::ptr_t far_gray_q1;
  afifo_types_pkg::ptr_t far_gray_q2;

  function automatic afifo_types_pkg::ptr_t bin2gray(input afifo_types_pkg::ptr_t b);
    return (b >> 1) ^ b;
  endfunction

  // msb passes through, each lower bit folds in the one above
  function automatic afifo_types_pkg::ptr_t gray2bin(input afifo_types_pkg::ptr_t g);
    afifo_types_pkg::ptr_t b;
    b[PW-1] = g[PW-1];
    for (int i = PW - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // next pointer, used for both the counter and the gray register
  always_comb begin
    if (inc) begin
      bin_nxt = bin_q + afifo_types_pkg::ptr_t'(1);
    end else begin
      bin_nxt = bin_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bin_q <= '0;
    end else begin
      bin_q <= bin_nxt;
    end
  end

  // gray copy straight from a flop, no glitches into the far domain
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gray_q <= '0;
    end else begin
      gray_q <= bin2gray(bin_nxt);
    end
  end

  // two-flop synchronizer for the other domain's pointer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      far_gray_q1 <= '0;
      far_gray_q2 <= '0;
    end else begin
      far_gray_q1 <= far_gray;
      far_gray_q2 <= far_gray_q1;
    end
  end

  assign ptr_bin     = bin_q;
  assign ptr_bin_nxt = bin_nxt;
  assign ptr_gray    = gray_q;
  assign far_bin     = gray2bin(far_gray_q2);   // only one bit changes per step

endmodule

// File: source/afifo_flag_ctrl.sv
module afifo_flag_ctrl #(
  parameter int unsigned AFULL_LVL  = afifo_cfg_pkg::AFULL_DEF,
  parameter int unsigned AEMPTY_LVL = afifo_cfg_pkg::AEMPTY_DEF
) (
  input  logic                   wr_clk,
  input  logic                   wr_rst_n,
  input  logic                   rd_clk,
  input  logic                   rd_rst_n,
  input  logic                   wr_en,
  input  logic                   rd_en,
  input  afifo_types_pkg::data_t wr_data,
  input  afifo_types_pkg::ptr_t  wr_ptr_bin,
  input  afifo_types_pkg::ptr_t  wr_ptr_bin_nxt,
  input  afifo_types_pkg::ptr_t  wr_far_bin,
  input  afifo_types_pkg::ptr_t  rd_ptr_bin,
  input  afifo_types_pkg::ptr_t  rd_ptr_bin_nxt,
  input  afifo_types_pkg::ptr_t  rd_far_bin,
  output logic                   wr_inc,
  output logic                   rd_inc,
  output logic                   full,
  output logic                   afull,
  output logic                   empty,
  output logic                   aempty,
  output afifo_types_pkg::data_t rd_data,
  afifo_ram_if.ctrl              ram
);

  localparam int unsigned AW = afifo_cfg_pkg::ADDR_W;

  localparam afifo_types_pkg::ptr_t DEPTH_P  = afifo_types_pkg::ptr_t'(afifo_cfg_pkg::DEPTH);
  localparam afifo_types_pkg::ptr_t AFULL_P  = afifo_types_pkg::ptr_t'(AFULL_LVL);
  localparam afifo_types_pkg::ptr_t AEMPTY_P = afifo_types_pkg::ptr_t'(AEMPTY_LVL);

  logic                  wr_vld;
  logic                  rd_vld;
  afifo_types_pkg::ptr_t wr_cnt;   // used entries as seen by the writer
  afifo_types_pkg::ptr_t rd_cnt;   // used entries as seen by the reader

  // enable plus flag is the whole handshake
  assign wr_vld = wr_en && !full;
  assign rd_vld = rd_en && !empty;

  assign wr_inc = wr_vld;
  assign rd_inc = rd_vld;

  // storage port, addressed by the current pointers
  assign ram.wr_en   = wr_vld;
  assign ram.wr_addr = wr_ptr_bin[AW-1:0];
  assign ram.wr_data = wr_data;
  assign ram.rd_en   = rd_vld;
  assign ram.rd_addr = rd_ptr_bin[AW-1:0];
  assign rd_data     = ram.rd_data;

  // counts after this edge, wrap bit makes the subtraction modulo 2*DEPTH
  assign wr_cnt = wr_ptr_bin_nxt - wr_far_bin;
  assign rd_cnt = rd_far_bin - rd_ptr_bin_nxt;

  // write side flags
  // far read pointer lags, so these are pessimistic
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= (wr_cnt == DEPTH_P);
      afull <= (wr_cnt >= AFULL_P);
    end
  end

  // read side flags, far write pointer lags too
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= (rd_cnt == '0);
      aempty <= (rd_cnt <= AEMPTY_P);
    end
  end

endmodule

// File: source/afifo_top.sv
module afifo_top #(
  parameter int unsigned AFULL_LVL  = afifo_cfg_pkg::AFULL_DEF,
  parameter int unsigned AEMPTY_LVL = afifo_cfg_pkg::AEMPTY_DEF
) (
  input  logic                   wr_clk,
  input  logic                   wr_rst_n,
  input  logic                   wr_en,
  input  afifo_types_pkg::data_t wr_data,
  input  logic                   rd_clk,
  input  logic                   rd_rst_n,
  input  logic                   rd_en,
  output afifo_types_pkg::data_t rd_data,
  output logic                   full,
  output logic                   afull,
  output logic                   empty,
  output logic                   aempty
);

  afifo_types_pkg::ptr_t wr_ptr_bin;
  afifo_types_pkg::ptr_t wr_ptr_bin_nxt;
  afifo_types_pkg::ptr_t wr_ptr_gray;
  afifo_types_pkg::ptr_t wr_far_bin;   // read pointer in wr_clk domain
  afifo_types_pkg::ptr_t rd_ptr_bin;
  afifo_types_pkg::ptr_t rd_ptr_bin_nxt;
  afifo_types_pkg::ptr_t rd_ptr_gray;
  afifo_types_pkg::ptr_t rd_far_bin;   // write pointer in rd_clk domain
  logic                  wr_inc;
  logic                  rd_inc;

  afifo_ram_if ram_if ();

  afifo_dpram u_dpram (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .ram      (ram_if.mem)
  );

  afifo_ptr_domain u_wr_ptr (
    .clk         (wr_clk),
    .rst_n       (wr_rst_n),
    .inc         (wr_inc),
    .far_gray    (rd_ptr_gray),
    .ptr_bin     (wr_ptr_bin),
    .ptr_bin_nxt (wr_ptr_bin_nxt),
    .ptr_gray    (wr_ptr_gray),
    .far_bin     (wr_far_bin)
  );

  afifo_ptr_domain u_rd_ptr (
    .clk         (rd_clk),
    .rst_n       (rd_rst_n),
    .inc         (rd_inc),
    .far_gray    (wr_ptr_gray),
    .ptr_bin     (rd_ptr_bin),
    .ptr_bin_nxt (rd_ptr_bin_nxt),
    .ptr_gray    (rd_ptr_gray),
    .far_bin     (rd_far_bin)
  );

  afifo_flag_ctrl #(
    .AFULL_LVL  (AFULL_LVL),
    .AEMPTY_LVL (AEMPTY_LVL)
  ) u_flag_ctrl (
    .wr_clk         (wr_clk),
    .wr_rst_n       (wr_rst_n),
    .rd_clk         (rd_clk),
    .rd_rst_n       (rd_rst_n),
    .wr_en          (wr_en),
    .rd_en          (rd_en),
    .wr_data        (wr_data),
    .wr_ptr_bin     (wr_ptr_bin),
    .wr_ptr_bin_nxt (wr_ptr_bin_nxt),
    .wr_far_bin     (wr_far_bin),
    .rd_ptr_bin     (rd_ptr_bin),
    .rd_ptr_bin_nxt (rd_ptr_bin_nxt),
    .rd_far_bin     (rd_far_bin),
    .wr_inc         (wr_inc),
    .rd_inc         (rd_inc),
    .full           (full),
    .afull          (afull),
    .empty          (empty),
    .aempty         (aempty),
    .rd_data        (rd_data),
    .ram            (ram_if.ctrl)
  );

endmodule

// File: verif/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;   // 50% duty
  end

endmodule

// File: verif/afifo_props.sv
module afifo_props (
  input logic                   wr_clk,
  input logic                   wr_rst_n,
  input logic                   rd_clk,
  input logic                   rd_rst_n,
  input logic                   rd_en,
  input logic                   full,
  input logic                   afull,
  input logic                   empty,
  input logic                   aempty,
  input afifo_types_pkg::data_t rd_data
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;

  // flags of both domains, sampled on the faster clock
  a_full_not_empty : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n || !wr_rst_n) !(full && empty)
  ) else begin
    $error("full and empty are high at the same time");
    fail_cnt++;
  end

  a_full_afull : assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) full |-> afull
  ) else begin
    $error("full is high while afull is low");
    fail_cnt++;
  end

  a_empty_aempty : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) empty |-> aempty
  ) else begin
    $error("empty is high while aempty is low");
    fail_cnt++;
  end

  // no accepted read, read register holds
  a_rd_data_hold : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) !(rd_en && !empty) |=> $stable(rd_data)
  ) else begin
    $error("rd_data changed without an accepted read");
    fail_cnt++;
  end

endmodule

// File: verif/afifo_tb.sv
module afifo_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 200;    // cycles per flag wait
  localparam int AFULL_AT   = 15;
  localparam int AEMPTY_AT  = 1;
  localparam int FIFO_WORDS = 16;
  localparam int RAND_WORDS = 300;
  localparam int RAND_LEN   = 256;
  localparam int RAND_LIMIT = 4000;

  logic                   wr_clk;
  logic                   rd_clk;
  logic                   wr_rst_n;
  logic                   rd_rst_n;
  logic                   wr_en;
  logic                   rd_en;
  logic                   full;
  logic                   afull;
  logic                   empty;
  logic                   aempty;
  afifo_types_pkg::data_t wr_data;
  afifo_types_pkg::data_t rd_data;

  afifo_types_pkg::data_t ref_q[$];   // accepted words, write order
  afifo_types_pkg::data_t last_rd;    // word rd_data should hold now
  int                     seed;
  int                     wr_rand [RAND_LEN];
  int                     rd_rand [RAND_LEN];
  int                     err_cnt;
  int                     err_mark;
  int                     tests_run;
  int                     tests_ok;
  string                  cur_test;

  tb_clock_gen #(.PERIOD_NS(4)) u_rd_clk (.clk(rd_clk));
  tb_clock_gen #(.PERIOD_NS(6)) u_wr_clk (.clk(wr_clk));

  afifo_top dut0 (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  bind afifo_top afifo_props u_props (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty),
    .rd_data  (rd_data)
  );

  task automatic check_value(input string what, input int exp, input int act);
    assert (act == exp) else begin
      $display("Fail %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic report_problem(input string msg);
    $display("%s: %s", cur_test, msg);
    err_cnt++;
  endtask

  // longer than the worst crossing delay on both sides
  task automatic settle;
    repeat (8) @(negedge wr_clk);
    repeat (8) @(negedge rd_clk);
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_mark = err_cnt;
    settle();
  endtask

  task automatic end_test;
    tests_run++;
    if (err_cnt == err_mark) begin
      tests_ok++;
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, err_cnt - err_mark);
    end
  endtask

  // all four flags against the reference fill level
  task automatic check_levels;
    int n;
    n = ref_q.size();
    check_value("full", n == FIFO_WORDS, full);
    check_value("afull", n >= AFULL_AT, afull);
    check_value("empty", n == 0, empty);
    check_value("aempty", n <= AEMPTY_AT, aempty);
  endtask

  task automatic write_word(input afifo_types_pkg::data_t d);
    int t;
    t = 0;
    @(negedge wr_clk);
    while (full && t < WAIT_LIMIT) begin
      wr_en = 1'b0;
      t++;
      @(negedge wr_clk);
    end
    if (full) begin
      wr_en = 1'b0;
      report_problem("full did not clear in time for a write");
    end else begin
      wr_en   = 1'b1;
      wr_data = d;
      ref_q.push_back(d);
    end
  endtask

  task automatic write_idle;
    @(negedge wr_clk);
    wr_en = 1'b0;
  endtask

  // write while full, must be ignored
  task automatic write_dropped(input afifo_types_pkg::data_t d);
    @(negedge wr_clk);
    check_value("full before dropped write", 1, full);
    wr_en   = 1'b1;
    wr_data = d;
    @(negedge wr_clk);
    wr_en = 1'b0;
  endtask

  task automatic read_word;
    int                     t;
    afifo_types_pkg::data_t exp;
    t = 0;
    @(negedge rd_clk);
    while (empty && t < WAIT_LIMIT) begin
      t++;
      @(negedge rd_clk);
    end
    if (empty) begin
      report_problem("empty did not clear in time for a read");
    end else if (ref_q.size() == 0) begin
      report_problem("empty is low although no word is outstanding");
    end else begin
      rd_en   = 1'b1;
      exp     = ref_q.pop_front();
      last_rd = exp;
      @(negedge rd_clk);
      rd_en = 1'b0;
      check_value("rd_data", exp, rd_data);
    end
  endtask

  task automatic wait_empty;
    int t;
    t = 0;
    while (!empty && t < WAIT_LIMIT) begin
      t++;
      @(negedge rd_clk);
    end
    if (!empty) report_problem("empty did not rise after the drain");
  endtask

  task automatic drive_random_writes;
    int sent;
    int t;
    int r;
    sent = 0;
    t    = 0;
    while (sent < RAND_WORDS && t < RAND_LIMIT) begin
      @(negedge wr_clk);
      r       = wr_rand[t % RAND_LEN];
      t++;
      wr_en   = (r[1:0] != 2'b00);   // about three writes in four
      wr_data = r[15:8];
      if (wr_en && !full) begin
        ref_q.push_back(wr_data);
        sent++;
      end
    end
    @(negedge wr_clk);
    wr_en = 1'b0;
    if (sent < RAND_WORDS) report_problem("random writer ran out of time");
  endtask

  task automatic drive_random_reads;
    int                     got;
    int                     t;
    logic                   pend;
    afifo_types_pkg::data_t exp;
    got  = 0;
    t    = 0;
    pend = 1'b0;
    while ((got < RAND_WORDS || pend) && t < RAND_LIMIT) begin
      @(negedge rd_clk);
      if (pend) check_value("rd_data", exp, rd_data);
      pend  = 1'b0;
      rd_en = (got < RAND_WORDS) && rd_rand[t % RAND_LEN][0];
      t++;
      if (rd_en && !empty) begin
        if (ref_q.size() == 0) begin
          report_problem("read accepted with no word outstanding");
        end else begin
          exp     = ref_q.pop_front();
          last_rd = exp;
          pend    = 1'b1;
          got++;
        end
      end
    end
    rd_en = 1'b0;
    if (got < RAND_WORDS) report_problem("random reader ran out of time");
  endtask

  task automatic test_reset;
    begin_test("reset");
    check_levels();
    check_value("rd_data", 0, rd_data);
    end_test();
  endtask

  task automatic test_ordering;
    begin_test("ordering");
    repeat (10) write_word(afifo_types_pkg::data_t'($random(seed)));
    write_idle();
    repeat (10) read_word();
    end_test();
  endtask

  task automatic test_full;
    begin_test("full");
    repeat (FIFO_WORDS) write_word(afifo_types_pkg::data_t'($random(seed)));
    write_idle();
    settle();
    check_levels();
    write_dropped(8'hee);
    write_dropped(8'hdd);
    repeat (FIFO_WORDS) read_word();
    settle();
    check_levels();   // a stored extra word shows up here
    end_test();
  endtask

  task automatic test_empty;
    begin_test("empty");
    repeat (3) begin
      @(negedge rd_clk);
      rd_en = 1'b1;
      @(negedge rd_clk);
      rd_en = 1'b0;
      check_value("rd_data", last_rd, rd_data);
      check_value("empty", 1, empty);
    end
    end_test();
  endtask

  task automatic test_thresholds;
    begin_test("thresholds");
    repeat (AFULL_AT) write_word(afifo_types_pkg::data_t'($random(seed)));
    write_idle();
    settle();
    check_levels();
    repeat (AFULL_AT - 1) read_word();
    settle();
    check_levels();
    read_word();
    settle();
    check_levels();
    end_test();
  endtask

  task automatic test_random;
    begin_test("random");
    for (int i = 0; i < RAND_LEN; i++) begin
      wr_rand[i] = $random(seed);
      rd_rand[i] = $random(seed);
    end
    fork
      drive_random_writes();
      drive_random_reads();
    join
    wait_empty();
    settle();
    check_levels();
    end_test();
  endtask

  initial begin
    wr_rst_n  = 1'b0;
    rd_rst_n  = 1'b0;
    wr_en     = 1'b0;
    rd_en     = 1'b0;
    wr_data   = '0;
    last_rd   = '0;
    seed      = 58;
    err_cnt   = 0;
    err_mark  = 0;
    tests_run = 0;
    tests_ok  = 0;
    cur_test  = "reset";
    repeat (5) @(posedge rd_clk);
    @(negedge rd_clk);
    rd_rst_n = 1'b1;
    @(negedge wr_clk);
    wr_rst_n = 1'b1;

    test_reset();
    test_ordering();
    test_full();
    test_empty();
    test_thresholds();
    test_random();

    $display("tests %0d, ok %0d, check errors %0d, assertion errors %0d",
             tests_run, tests_ok, err_cnt, dut0.u_props.fail_cnt);
    if (err_cnt == 0 && dut0.u_props.fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: afifo_top.f
source/afifo_cfg_pkg.sv
source/afifo_types_pkg.sv
source/afifo_ram_if.sv
source/afifo_dpram.sv
source/afifo_ptr_domain.sv
source/afifo_flag_ctrl.sv
source/afifo_top.sv
verif/tb_clock_gen.sv
verif/afifo_props.sv
verif/afifo_tb.sv

// File: Bender.yml
package:
  name: afifo

sources:
  - files:
      - source/afifo_cfg_pkg.sv
      - source/afifo_types_pkg.sv
      - source/afifo_ram_if.sv
      - source/afifo_dpram.sv
      - source/afifo_ptr_domain.sv
      - source/afifo_flag_ctrl.sv
      - source/afifo_top.sv
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/afifo_props.sv
      - verif/afifo_tb.sv
